// File: logic/cachePackage.sv
package cachePackage;

	// word address and data word
	localparam int ADDRESS_WIDTH = 8;
	localparam int DATA_WIDTH    = 16;

	// four words per block, four sets
	localparam int OFFSET_WIDTH = 2;
	localparam int INDEX_WIDTH  = 2;

	// MSI line state
	typedef enum logic [1 : 0] {
		INVALID,
		SHARED,
		MODIFIED
	} CoherenceState;

	typedef enum logic [2 : 0] {
		NONE,
		BUS_READ,
		BUS_READ_EXCLUSIVE,
		BUS_WRITEBACK,
		BUS_INVALIDATE
	} BusCommand;

	// one processor access
	typedef struct packed {
		logic                         read;
		logic                         write;
		logic [ADDRESS_WIDTH - 1 : 0] address;
		logic [DATA_WIDTH - 1 : 0]    writeData;
	} CpuRequest;

	typedef struct packed {
		logic                      functionComplete;
		logic [DATA_WIDTH - 1 : 0] readData;
	} CpuResponse;

	// controller to main memory
	typedef struct packed {
		logic                         readEnabled;
		logic                         writeEnabled;
		logic [ADDRESS_WIDTH - 1 : 0] address;
		logic [DATA_WIDTH - 1 : 0]    dataOut;
	} BusAccess;

	// protocol to controller
	typedef struct packed {
		logic          writeBackRequired;
		logic          readExclusiveRequired;
		logic          invalidateRequired;
		CoherenceState stateIn;
	} ProtocolDecision;

endpackage : cachePackage

// File: logic/cacheStore.sv
`timescale 1ns/1ps

module cacheStore #(
	parameter int OFFSET_WIDTH = cachePackage::OFFSET_WIDTH,
	parameter int INDEX_WIDTH  = cachePackage::INDEX_WIDTH,
	parameter int TAG_WIDTH    = cachePackage::ADDRESS_WIDTH - cachePackage::OFFSET_WIDTH
		- cachePackage::INDEX_WIDTH,
	parameter int DATA_WIDTH   = cachePackage::DATA_WIDTH
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic [INDEX_WIDTH - 1 : 0]  index,
	input  logic [OFFSET_WIDTH - 1 : 0] offset,
	input  logic [TAG_WIDTH - 1 : 0]    tagIn,
	input  logic [DATA_WIDTH - 1 : 0]   dataIn,
	input  cachePackage::CoherenceState stateIn,
	input  logic                        writeData,
	input  logic                        writeTag,
	input  logic                        writeState,
	output logic                        hit,
	output logic [TAG_WIDTH - 1 : 0]    tagOut,
	output logic [DATA_WIDTH - 1 : 0]   dataOut,
	output cachePackage::CoherenceState stateOut
);
	import cachePackage::*;

	localparam int SET_COUNT   = 2 ** INDEX_WIDTH;
	localparam int BLOCK_WORDS = 2 ** OFFSET_WIDTH;

	logic [DATA_WIDTH - 1 : 0] dataArray [SET_COUNT][BLOCK_WORDS];
	logic [TAG_WIDTH - 1 : 0]  tagArray [SET_COUNT];
	CoherenceState             stateArray [SET_COUNT];

	// every line starts out invalid
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int set = 0; set < SET_COUNT; set++) begin
				stateArray[set] <= INVALID;
			end
		end else if (writeState) begin
			stateArray[index] <= stateIn;
		end
	end

	always_ff @(posedge clock) begin
		if (writeTag) begin
			tagArray[index] <= tagIn;
		end
	end

	always_ff @(posedge clock) begin
		if (writeData) begin
			dataArray[index][offset] <= dataIn;
		end
	end

	assign tagOut   = tagArray[index];
	assign stateOut = stateArray[index];
	assign dataOut  = dataArray[index][offset];

	// tag compare only counts on a valid line
	assign hit = stateOut != INVALID && tagOut == tagIn;

	// a new tag never lands without its state
	assert property (@(posedge clock) disable iff (reset)
		writeTag |-> writeState);

endmodule : cacheStore

// File: logic/coherenceProtocol.sv
`timescale 1ns/1ps

module coherenceProtocol (
	input  logic                          hit,
	input  logic                          read,
	input  logic                          write,
	input  cachePackage::CoherenceState   stateOut,
	output cachePackage::ProtocolDecision decision
);
	import cachePackage::*;

	// MSI table for a single node
	always_comb begin
		decision.writeBackRequired     = 1'b0;
		decision.readExclusiveRequired = 1'b0;
		decision.invalidateRequired    = 1'b0;

		// a read fill stays shared, any write ends up modified
		decision.stateIn = write ? MODIFIED : SHARED;

		if (read || write) begin
			case (stateOut)
				INVALID: begin
					decision.readExclusiveRequired = write;
				end

				SHARED: begin
					if (hit) begin
						// others may hold copies
						decision.invalidateRequired = write;
					end else begin
						decision.readExclusiveRequired = write;
					end
				end

				MODIFIED: begin
					if (!hit) begin
						// dirty victim goes out first
						decision.writeBackRequired     = 1'b1;
						decision.readExclusiveRequired = write;
					end
				end

				default: begin
					decision.writeBackRequired = 1'b0;
				end
			endcase
		end
	end

endmodule : coherenceProtocol

// File: logic/cpuController.sv
`timescale 1ns/1ps

module cpuController #(
	parameter int OFFSET_WIDTH = cachePackage::OFFSET_WIDTH,
	parameter int INDEX_WIDTH  = cachePackage::INDEX_WIDTH,
	parameter int TAG_WIDTH    = cachePackage::ADDRESS_WIDTH - cachePackage::OFFSET_WIDTH
		- cachePackage::INDEX_WIDTH,
	parameter int DATA_WIDTH   = cachePackage::DATA_WIDTH
) (
	input  logic                          clock,
	input  logic                          reset,
	input  cachePackage::CpuRequest       request,
	output cachePackage::CpuResponse      response,
	input  cachePackage::ProtocolDecision decision,
	input  logic                          hit,
	input  logic [TAG_WIDTH - 1 : 0]      tagOut,
	input  cachePackage::CoherenceState   stateOut,
	input  logic [DATA_WIDTH - 1 : 0]     cacheData,
	output logic [INDEX_WIDTH - 1 : 0]    index,
	output logic [OFFSET_WIDTH - 1 : 0]   offset,
	output logic [TAG_WIDTH - 1 : 0]      tagIn,
	output logic [DATA_WIDTH - 1 : 0]     fillData,
	output cachePackage::CoherenceState   stateIn,
	output logic                          writeData,
	output logic                          writeTag,
	output logic                          writeState,
	output cachePackage::BusAccess        bus,
	input  logic                          memoryComplete,
	input  logic [DATA_WIDTH - 1 : 0]     memoryData,
	input  logic                          grant,
	input  logic                          isInvalidated,
	output cachePackage::BusCommand       busCommand,
	output logic                          busRequest,
	output logic                          accessEnable
);
	import cachePackage::*;

	typedef enum logic [1 : 0] {
		READ_GRANT_WAIT,
		READ_WAIT_COMPLETE,
		READ_WRITE_DATA,
		READ_WRITE_TAG_STATE
	} ReadState;

	typedef enum logic [1 : 0] {
		EXCLUSIVE_GRANT_WAIT,
		EXCLUSIVE_WAIT_COMPLETE,
		EXCLUSIVE_WRITE_DATA,
		EXCLUSIVE_WRITE_TAG_STATE
	} ReadExclusiveState;

	typedef enum logic [1 : 0] {
		WRITEBACK_GRANT_WAIT,
		WRITEBACK_WAIT_COMPLETE,
		WRITEBACK_WRITE_STATE
	} WriteBackState;

	typedef enum logic {
		INVALIDATE_WAIT_ACK,
		INVALIDATE_WRITE_STATE
	} InvalidateState;

	ReadState                    readState;
	ReadExclusiveState           readExclusiveState;
	WriteBackState               writeBackState;
	InvalidateState              invalidateState;
	logic [OFFSET_WIDTH - 1 : 0] wordCounter;
	logic [TAG_WIDTH - 1 : 0]    masterTag;
	logic                        requestPresent;
	logic                        hitWrite;
	logic                        fillWrite;
	logic                        tagWrite;
	logic                        stateWrite;
	logic                        busReadEnabled;
	logic                        busWriteEnabled;

	assign requestPresent = request.read || request.write;

	assign tagIn    = request.address[OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
	assign index    = request.address[OFFSET_WIDTH +: INDEX_WIDTH];
	assign offset   = hit ? request.address[OFFSET_WIDTH - 1 : 0] : wordCounter;
	assign fillData = hit ? request.writeData : memoryData;
	assign stateIn  = (!hit && decision.writeBackRequired) ? INVALID : decision.stateIn;

	// hit writes land on the same edge that completes the access
	assign hitWrite   = requestPresent && hit && !decision.invalidateRequired && request.write;
	assign writeData  = fillWrite || hitWrite;
	assign writeState = stateWrite || hitWrite;
	assign writeTag   = tagWrite;

	// victim tag while draining, request tag while filling
	assign masterTag = decision.writeBackRequired ? tagOut : tagIn;

	always_comb begin
		bus.readEnabled  = busReadEnabled;
		bus.writeEnabled = busWriteEnabled;
		bus.address      = {masterTag, index, wordCounter};
		bus.dataOut      = cacheData;
	end

	always_comb begin
		busCommand = NONE;
		if (requestPresent) begin
			if (hit) begin
				if (decision.invalidateRequired) begin
					busCommand = BUS_INVALIDATE;
				end
			end else if (decision.writeBackRequired) begin
				busCommand = BUS_WRITEBACK;
			end else if (decision.readExclusiveRequired) begin
				busCommand = BUS_READ_EXCLUSIVE;
			end else begin
				busCommand = BUS_READ;
			end
		end
	end

	assign busRequest = busCommand != NONE;

	task readBlock();
		case (readState)
			READ_GRANT_WAIT: begin
				if (grant) begin
					busReadEnabled <= 1'b1;
					readState      <= READ_WAIT_COMPLETE;
				end
			end
			READ_WAIT_COMPLETE: begin
				if (memoryComplete) begin
					fillWrite <= 1'b1;
					readState <= READ_WRITE_DATA;
				end
			end
			READ_WRITE_DATA: begin
				fillWrite      <= 1'b0;
				busReadEnabled <= 1'b0;
				wordCounter    <= wordCounter + 1'b1;
				if (&wordCounter) begin
					tagWrite   <= 1'b1;
					stateWrite <= 1'b1;
					readState  <= READ_WRITE_TAG_STATE;
				end else begin
					readState <= READ_GRANT_WAIT;
				end
			end
			READ_WRITE_TAG_STATE: begin
				tagWrite   <= 1'b0;
				stateWrite <= 1'b0;
				readState  <= READ_GRANT_WAIT;
			end
		endcase
	endtask : readBlock

	task readExclusiveBlock();
		case (readExclusiveState)
			EXCLUSIVE_GRANT_WAIT: begin
				if (grant) begin
					busReadEnabled     <= 1'b1;
					readExclusiveState <= EXCLUSIVE_WAIT_COMPLETE;
				end
			end
			EXCLUSIVE_WAIT_COMPLETE: begin
				if (memoryComplete) begin
					fillWrite          <= 1'b1;
					readExclusiveState <= EXCLUSIVE_WRITE_DATA;
				end
			end
			EXCLUSIVE_WRITE_DATA: begin
				fillWrite      <= 1'b0;
				busReadEnabled <= 1'b0;
				if (&wordCounter) begin
					// ownership needs the acknowledgement of the other caches
					if (isInvalidated) begin
						tagWrite           <= 1'b1;
						stateWrite         <= 1'b1;
						wordCounter        <= wordCounter + 1'b1;
						readExclusiveState <= EXCLUSIVE_WRITE_TAG_STATE;
					end
				end else begin
					wordCounter        <= wordCounter + 1'b1;
					readExclusiveState <= EXCLUSIVE_GRANT_WAIT;
				end
			end
			EXCLUSIVE_WRITE_TAG_STATE: begin
				tagWrite           <= 1'b0;
				stateWrite         <= 1'b0;
				readExclusiveState <= EXCLUSIVE_GRANT_WAIT;
			end
		endcase
	endtask : readExclusiveBlock

	task writeBackBlock();
		case (writeBackState)
			WRITEBACK_GRANT_WAIT: begin
				if (grant) begin
					busWriteEnabled <= 1'b1;
					writeBackState  <= WRITEBACK_WAIT_COMPLETE;
				end
			end
			WRITEBACK_WAIT_COMPLETE: begin
				if (memoryComplete) begin
					busWriteEnabled <= 1'b0;
					wordCounter     <= wordCounter + 1'b1;
					if (&wordCounter) begin
						// line drops to invalid, the refill follows
						stateWrite     <= 1'b1;
						writeBackState <= WRITEBACK_WRITE_STATE;
					end else begin
						writeBackState <= WRITEBACK_GRANT_WAIT;
					end
				end
			end
			WRITEBACK_WRITE_STATE: begin
				stateWrite     <= 1'b0;
				writeBackState <= WRITEBACK_GRANT_WAIT;
			end
			default: begin
				writeBackState <= WRITEBACK_GRANT_WAIT;
			end
		endcase
	endtask : writeBackBlock

	task invalidateBlock();
		case (invalidateState)
			INVALIDATE_WAIT_ACK: begin
				if (grant && isInvalidated) begin
					stateWrite      <= 1'b1;
					invalidateState <= INVALIDATE_WRITE_STATE;
				end
			end
			INVALIDATE_WRITE_STATE: begin
				stateWrite      <= 1'b0;
				invalidateState <= INVALIDATE_WAIT_ACK;
			end
		endcase
	endtask : invalidateBlock

	task serveRequest();
		// toggling keeps a held request from stretching the pulse
		response.functionComplete <= !response.functionComplete;
		response.readData         <= cacheData;
		accessEnable              <= 1'b1;
	endtask : serveRequest

	task controllerReset();
		readState                 <= READ_GRANT_WAIT;
		readExclusiveState        <= EXCLUSIVE_GRANT_WAIT;
		writeBackState            <= WRITEBACK_GRANT_WAIT;
		invalidateState           <= INVALIDATE_WAIT_ACK;
		wordCounter               <= '0;
		fillWrite                 <= 1'b0;
		tagWrite                  <= 1'b0;
		stateWrite                <= 1'b0;
		busReadEnabled            <= 1'b0;
		busWriteEnabled           <= 1'b0;
		response.functionComplete <= 1'b0;
		accessEnable              <= 1'b0;
	endtask : controllerReset

	always_ff @(posedge clock) begin
		if (reset) begin
			controllerReset();
		end else begin
			response.functionComplete <= 1'b0;
			accessEnable              <= 1'b0;
			if (requestPresent) begin
				if (hit) begin
					if (decision.invalidateRequired) begin
						invalidateBlock();
					end else begin
						serveRequest();
					end
				end else if (decision.writeBackRequired) begin
					writeBackBlock();
				end else if (decision.readExclusiveRequired) begin
					readExclusiveBlock();
				end else begin
					readBlock();
				end
			end
		end
	end

	// idle processor means an idle bus
	assert property (@(posedge clock) disable iff (reset)
		!(request.read || request.write) |->
			busCommand == NONE && !bus.readEnabled && !bus.writeEnabled);

	assert property (@(posedge clock) disable iff (reset)
		!(bus.readEnabled && bus.writeEnabled));

	// Memory is only ever written from a dirty line of the store.
	assert property (@(posedge clock) disable iff (reset)
		bus.writeEnabled |-> stateOut == MODIFIED);

endmodule : cpuController

// File: logic/mainMemory.sv
`timescale 1ns/1ps

module mainMemory #(
	parameter int ADDRESS_WIDTH = cachePackage::ADDRESS_WIDTH,
	parameter int DATA_WIDTH    = cachePackage::DATA_WIDTH
) (
	input  logic                      clock,
	input  logic                      reset,
	input  cachePackage::BusAccess    bus,
	output logic                      functionComplete,
	output logic [DATA_WIDTH - 1 : 0] readData
);
	localparam int DEPTH = 2 ** ADDRESS_WIDTH;

	logic [DATA_WIDTH - 1 : 0] memory [DEPTH];
	logic                      accessEnabled;
	logic                      accessDone;

	assign accessEnabled = bus.readEnabled || bus.writeEnabled;

	// one pulse per enable, re-armed once the enable drops
	always_ff @(posedge clock) begin
		if (reset) begin
			functionComplete <= 1'b0;
			accessDone       <= 1'b0;
			for (int word = 0; word < DEPTH; word++) begin
				// each word starts out holding its own address
				memory[word] <= DATA_WIDTH'(word);
			end
		end else begin
			functionComplete <= 1'b0;
			if (accessEnabled && !accessDone) begin
				functionComplete <= 1'b1;
				accessDone       <= 1'b1;
				if (bus.writeEnabled) begin
					memory[bus.address] <= bus.dataOut;
				end else begin
					readData <= memory[bus.address];
				end
			end else if (!accessEnabled) begin
				accessDone <= 1'b0;
			end
		end
	end

endmodule : mainMemory

// File: logic/cacheSubsystem.sv
`timescale 1ns/1ps

module cacheSubsystem #(
	parameter int ADDRESS_WIDTH = cachePackage::ADDRESS_WIDTH,
	parameter int DATA_WIDTH    = cachePackage::DATA_WIDTH,
	parameter int OFFSET_WIDTH  = cachePackage::OFFSET_WIDTH,
	parameter int INDEX_WIDTH   = cachePackage::INDEX_WIDTH
) (
	input  logic                     clock,
	input  logic                     reset,
	input  cachePackage::CpuRequest  request,
	output cachePackage::CpuResponse response,
	input  logic                     grant,
	input  logic                     isInvalidated,
	output cachePackage::BusCommand  busCommand,
	output logic                     busRequest,
	output logic                     accessEnable
);
	import cachePackage::*;

	localparam int TAG_WIDTH = ADDRESS_WIDTH - OFFSET_WIDTH - INDEX_WIDTH;

	logic [INDEX_WIDTH - 1 : 0]  index;
	logic [OFFSET_WIDTH - 1 : 0] offset;
	logic [TAG_WIDTH - 1 : 0]    tagIn;
	logic [TAG_WIDTH - 1 : 0]    tagOut;
	logic [DATA_WIDTH - 1 : 0]   fillData;
	logic [DATA_WIDTH - 1 : 0]   cacheData;
	logic [DATA_WIDTH - 1 : 0]   memoryData;
	logic                        writeData;
	logic                        writeTag;
	logic                        writeState;
	logic                        hit;
	logic                        memoryComplete;
	CoherenceState               stateIn;
	CoherenceState               stateOut;
	ProtocolDecision             decision;
	BusAccess                    bus;

	cacheStore #(
		.OFFSET_WIDTH(OFFSET_WIDTH),
		.INDEX_WIDTH (INDEX_WIDTH),
		.TAG_WIDTH   (TAG_WIDTH),
		.DATA_WIDTH  (DATA_WIDTH)
	) i_cacheStore (
		.clock     (clock),
		.reset     (reset),
		.index     (index),
		.offset    (offset),
		.tagIn     (tagIn),
		.dataIn    (fillData),
		.stateIn   (stateIn),
		.writeData (writeData),
		.writeTag  (writeTag),
		.writeState(writeState),
		.hit       (hit),
		.tagOut    (tagOut),
		.dataOut   (cacheData),
		.stateOut  (stateOut)
	);

	coherenceProtocol i_coherenceProtocol (
		.hit     (hit),
		.read    (request.read),
		.write   (request.write),
		.stateOut(stateOut),
		.decision(decision)
	);

	cpuController #(
		.OFFSET_WIDTH(OFFSET_WIDTH),
		.INDEX_WIDTH (INDEX_WIDTH),
		.TAG_WIDTH   (TAG_WIDTH),
		.DATA_WIDTH  (DATA_WIDTH)
	) i_cpuController (
		.clock         (clock),
		.reset         (reset),
		.request       (request),
		.response      (response),
		.decision      (decision),
		.hit           (hit),
		.tagOut        (tagOut),
		.stateOut      (stateOut),
		.cacheData     (cacheData),
		.index         (index),
		.offset        (offset),
		.tagIn         (tagIn),
		.fillData      (fillData),
		.stateIn       (stateIn),
		.writeData     (writeData),
		.writeTag      (writeTag),
		.writeState    (writeState),
		.bus           (bus),
		.memoryComplete(memoryComplete),
		.memoryData    (memoryData),
		.grant         (grant),
		.isInvalidated (isInvalidated),
		.busCommand    (busCommand),
		.busRequest    (busRequest),
		.accessEnable  (accessEnable)
	);

	mainMemory #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.DATA_WIDTH   (DATA_WIDTH)
	) i_mainMemory (
		.clock           (clock),
		.reset           (reset),
		.bus             (bus),
		.functionComplete(memoryComplete),
		.readData        (memoryData)
	);

endmodule : cacheSubsystem

// File: tb/cacheSubsystemTb.sv
`timescale 1ns/1ps

module cacheSubsystemTb;
	import cachePackage::*;

	localparam int CYCLES_PER_ACCESS = 200;
	localparam int ACK_DELAY         = 4;
	localparam int BLOCK_WORDS       = 2 ** OFFSET_WIDTH;
	localparam int WORD_CYCLES       = 3;

	logic       clock;
	logic       reset;
	CpuRequest  request;
	CpuResponse response;
	logic       grant;
	logic       isInvalidated;
	BusCommand  busCommand;
	logic       busRequest;
	logic       accessEnable;

	integer seed;
	int     lineCount;
	int     errorCount;
	int     stallCycles;

	// golden accesses, one entry per line
	logic                         isWriteList [$];
	logic [ADDRESS_WIDTH - 1 : 0] addressList [$];
	logic [DATA_WIDTH - 1 : 0]    writeDataList [$];
	logic [DATA_WIDTH - 1 : 0]    expectReadList [$];
	BusCommand                    expectCommandList [$];

	cacheSubsystem #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.DATA_WIDTH   (DATA_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH),
		.INDEX_WIDTH  (INDEX_WIDTH)
	) i_cacheSubsystem (
		.clock        (clock),
		.reset        (reset),
		.request      (request),
		.response     (response),
		.grant        (grant),
		.isInvalidated(isInvalidated),
		.busCommand   (busCommand),
		.busRequest   (busRequest),
		.accessEnable (accessEnable)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	function automatic BusCommand commandFromText(string text);
		case (text)
			"BUS_READ":           return BUS_READ;
			"BUS_READ_EXCLUSIVE": return BUS_READ_EXCLUSIVE;
			"BUS_WRITEBACK":      return BUS_WRITEBACK;
			"BUS_INVALIDATE":     return BUS_INVALIDATE;
			default:              return NONE;
		endcase
	endfunction

	function automatic string commandText(BusCommand command);
		case (command)
			BUS_READ:           return "BUS_READ";
			BUS_READ_EXCLUSIVE: return "BUS_READ_EXCLUSIVE";
			BUS_WRITEBACK:      return "BUS_WRITEBACK";
			BUS_INVALIDATE:     return "BUS_INVALIDATE";
			default:            return "NONE";
		endcase
	endfunction

	// data words moved over the bus, by first command
	function automatic int busWords(BusCommand command);
		case (command)
			BUS_READ, BUS_READ_EXCLUSIVE: return BLOCK_WORDS;
			BUS_WRITEBACK:                return 2 * BLOCK_WORDS;
			default:                      return 0;
		endcase
	endfunction

	task automatic readGolden();
		int                           fd;
		int                           fields;
		string                        line;
		string                        opText;
		string                        commandName;
		logic [ADDRESS_WIDTH - 1 : 0] address;
		logic [DATA_WIDTH - 1 : 0]    writeValue;
		logic [DATA_WIDTH - 1 : 0]    readValue;

		fd = $fopen("tb/cacheGolden.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/cacheGolden.txt");
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) == 0) begin
					break;
				end
				// skip comments and blank lines
				if (line.len() < 2 || line.substr(0, 0) == "#") begin
					continue;
				end
				fields = $sscanf(line, "%s %h %h %h %s", opText, address, writeValue,
					readValue, commandName);
				if (fields == 5) begin
					isWriteList.push_back(opText == "write");
					addressList.push_back(address);
					writeDataList.push_back(writeValue);
					expectReadList.push_back(readValue);
					expectCommandList.push_back(commandFromText(commandName));
				end
			end
			$fclose(fd);
			lineCount = addressList.size();
		end
	endtask

	// random grant stretches
	initial begin : grantDriver
		int stretch;

		seed = 32'hfb67a7c2;
		grant = 1'b0;
		// long opening stretch holds off the first miss
		stretch = 30;
		forever begin
			@(posedge clock);
			#1;
			if (stretch > 0) begin
				stretch--;
				grant = 1'b0;
			end else if (($random(seed) & 7) == 0) begin
				stretch = 1 + ($random(seed) & 7);
				grant = 1'b0;
			end else begin
				grant = 1'b1;
			end
		end
	end

	initial begin : watchdog
		wait (lineCount > 0);
		repeat (lineCount * CYCLES_PER_ACCESS) @(posedge clock);
		$display("timeout: the accesses did not finish within %0d cycles",
			lineCount * CYCLES_PER_ACCESS);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		int                        cycleCount;
		int                        grantCycles;
		int                        passCount;
		int                        failCount;
		int                        ackCountdown;
		int                        errorsBefore;
		logic                      ackRaised;
		logic                      needsAck;
		logic                      done;
		BusCommand                 firstCommand;
		logic [DATA_WIDTH - 1 : 0] readValue;

		request = '0;
		isInvalidated = 1'b0;
		reset = 1'b1;
		lineCount = 0;
		errorCount = 0;
		stallCycles = 0;
		passCount = 0;
		failCount = 0;
		readGolden();

		repeat (10) @(posedge clock);
		#1;
		assert (!response.functionComplete && !accessEnable) else begin
			$display("functionComplete or accessEnable was high right after reset");
			errorCount++;
		end
		reset = 1'b0;

		for (int access = 0; access < lineCount; access++) begin
			@(posedge clock);
			#1;
			request.read = !isWriteList[access];
			request.write = isWriteList[access];
			request.address = addressList[access];
			request.writeData = writeDataList[access];
			firstCommand = NONE;
			ackRaised = 1'b0;
			needsAck = 1'b0;
			ackCountdown = ACK_DELAY;
			cycleCount = 0;
			grantCycles = 0;
			done = 1'b0;
			errorsBefore = errorCount;

			while (!done) begin
				// mid-cycle look at the bus side
				#1;
				if (firstCommand == NONE) begin
					firstCommand = busCommand;
				end
				if (busCommand == BUS_INVALIDATE || busCommand == BUS_READ_EXCLUSIVE) begin
					needsAck = 1'b1;
				end
				if (busRequest && !grant) begin
					stallCycles++;
				end
				if (grant) begin
					grantCycles++;
				end
				assert (busRequest == (busCommand != NONE)) else begin
					$display("Error at %0t: busRequest expected %b, got %b", $time,
						busCommand != NONE, busRequest);
					errorCount++;
				end
				@(posedge clock);
				#1;
				cycleCount++;
				if (response.functionComplete) begin
					done = 1'b1;
				end else if (needsAck && !ackRaised) begin
					if (ackCountdown == 0) begin
						isInvalidated = 1'b1;
						ackRaised = 1'b1;
					end else begin
						ackCountdown--;
					end
				end
				assert (accessEnable == done) else begin
					$display("Error at %0t: accessEnable expected %b, got %b", $time,
						done, accessEnable);
					errorCount++;
				end
			end

			readValue = response.readData;
			request = '0;
			isInvalidated = 1'b0;

			if (!isWriteList[access]) begin
				assert (readValue == expectReadList[access]) else begin
					$display("Error at %0t: readData expected %h, got %h", $time,
						expectReadList[access], readValue);
					errorCount++;
				end
			end
			assert (firstCommand == expectCommandList[access]) else begin
				$display("Error at %0t: busCommand expected %s, got %s", $time,
					commandText(expectCommandList[access]), commandText(firstCommand));
				errorCount++;
			end
			assert (!needsAck || ackRaised) else begin
				$display("access %0d finished before the invalidation was acknowledged",
					access);
				errorCount++;
			end
			if (expectCommandList[access] == NONE) begin
				assert (cycleCount == 1) else begin
					$display("Error at %0t: functionComplete expected after 1 cycle, got %0d",
						$time, cycleCount);
					errorCount++;
				end
			end else begin
				assert (cycleCount >= WORD_CYCLES * busWords(expectCommandList[access]))
				else begin
					$display("access %0d finished in %0d cycles, too fast for %0d bus words",
						access, cycleCount, busWords(expectCommandList[access]));
					errorCount++;
				end
				assert (grantCycles >= busWords(expectCommandList[access])) else begin
					$display("access %0d moved %0d bus words with grant high for %0d cycles",
						access, busWords(expectCommandList[access]), grantCycles);
					errorCount++;
				end
			end

			if (errorCount == errorsBefore) begin
				passCount++;
			end else begin
				failCount++;
			end
			$display("access %0d: %s %h, readData %h, first command %s, %0d cycles, %s",
				access, isWriteList[access] ? "write" : "read", addressList[access],
				readValue, commandText(firstCommand), cycleCount,
				(errorCount == errorsBefore) ? "ok" : "FAILED");
		end

		assert (lineCount > 0) else begin
			$display("the golden file held no accesses");
			errorCount++;
		end

		$display("accesses %0d, passed %0d, failed %0d, errors %0d, stall cycles %0d",
			lineCount, passCount, failCount, errorCount, stallCycles);
		if (errorCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : cacheSubsystemTb

// File: tb/cacheGolden.txt
# op address writeData expectedRead firstBusCommand (all values hex)
# expectedRead is ignored for writes, memory word N starts out holding N
read  10 0000 0010 BUS_READ
read  13 0000 0013 NONE
read  11 0000 0011 NONE
write 24 beef 0000 BUS_READ_EXCLUSIVE
read  24 0000 beef NONE
read  27 0000 0027 NONE
write 12 1234 0000 BUS_INVALIDATE
read  12 0000 1234 NONE
read  10 0000 0010 NONE
read  52 0000 0052 BUS_WRITEBACK
read  12 0000 1234 BUS_READ
read  28 0000 0028 BUS_READ
write 29 00aa 0000 BUS_INVALIDATE
write 2a 00bb 0000 NONE
read  29 0000 00aa NONE
write 6b 5a5a 0000 BUS_WRITEBACK
read  6b 0000 5a5a NONE
read  2a 0000 00bb BUS_WRITEBACK
read  6b 0000 5a5a BUS_READ
read  24 0000 beef NONE
read  34 0000 0034 BUS_WRITEBACK
read  24 0000 beef BUS_READ
read  3c 0000 003c BUS_READ
read  3f 0000 003f NONE
write fc c0de 0000 BUS_READ_EXCLUSIVE
read  fc 0000 c0de NONE
read  3f 0000 003f BUS_WRITEBACK
read  fc 0000 c0de BUS_READ

// File: vlog.f
logic/cachePackage.sv
logic/cacheStore.sv
logic/coherenceProtocol.sv
logic/cpuController.sv
logic/mainMemory.sv
logic/cacheSubsystem.sv
tb/cacheSubsystemTb.sv
